//--- tb.f
+incdir+.
ibuf_cfg_pkg.sv
instr_pkg.sv
bank_fifo.sv
fetch_align.sv
dispatch_count.sv
multi_channel_fifo.sv
instr_buffer.sv
tb_instr_buffer.sv

//--- run.sh
#!/bin/bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_instr_buffer -f tb.f &&
./obj_dir/Vtb_instr_buffer | tee /dev/stderr | grep -qx "TESTS PASSED" &&
echo "Simulation run succeeded" ||
{ echo "Simulation run failed"; exit 1; }

//--- tb_instr_buffer_tasks.svh
`ifndef TB_INSTR_BUFFER_TASKS_SVH
`define TB_INSTR_BUFFER_TASKS_SVH

instr_t model_q[$]; // Expected contents, oldest first
int model_rd_bank = 0; // Bank that holds model_q[0]

task automatic model_reset();
	model_q.delete();
	model_rd_bank = 0;
endtask

// Entries sit in consecutive banks starting at the read bank
function automatic int bank_fill(input int b);
	int n;
	n = 0;
	for (int i = 0; i < model_q.size(); i++) begin
		if ((model_rd_bank + i) % BANK == b) begin
			n++;
		end
	end
	return n;
endfunction

function automatic logic exp_ready();
	int full;
	full = 0;
	for (int b = 0; b < BANK; b++) begin
		if (bank_fill(b) >= DEPTH) begin
			full++;
		end
	end
	return (full <= BANK - WRITE_PORT);
endfunction

function automatic rd_mask_t exp_valid();
	rd_mask_t m;
	m = '0;
	for (int i = 0; i < READ_PORT; i++) begin
		m[i] = (model_q.size() > i);
	end
	return m;
endfunction

function automatic rd_cnt_t exp_taken();
	int n;
	n = model_q.size();
	if (n > READ_PORT) begin
		n = READ_PORT;
	end
	if (int'(dec_slots_i) < n) begin
		n = int'(dec_slots_i);
	end
	return rd_cnt_t'(n);
endfunction

task automatic model_step();
	int taken;
	logic accept;
	taken = int'(exp_taken());
	accept = fetch_valid_i && exp_ready(); // Ready from the state before the edge
	if (flush_i) begin
		model_reset();
	end else begin
		repeat (taken) begin
			void'(model_q.pop_front());
			model_rd_bank = (model_rd_bank + 1) % BANK;
		end
		if (accept) begin
			for (int k = 0; k < WRITE_PORT; k++) begin
				if (fetch_mask_i[k]) begin
					model_q.push_back(fetch_instr_i[k]);
				end
			end
		end
	end
endtask

function automatic wr_lanes_t random_lanes();
	wr_lanes_t lanes;
	for (int k = 0; k < WRITE_PORT; k++) begin
		lanes[k] = instr_t'($random(seed));
	end
	return lanes;
endfunction

// Returns at the negedge before the accepting edge
task automatic send_packet(input wr_mask_t mask, input rd_cnt_t slots);
	int waited;
	waited = 0;
	@(posedge clk);
	fetch_valid_i <= 1'b1;
	fetch_mask_i <= mask;
	fetch_instr_i <= random_lanes();
	dec_slots_i <= slots;
	@(negedge clk);
	while (!fetch_ready_o && waited < HOLD_LIMIT) begin
		@(posedge clk);
		dec_slots_i <= rd_cnt_t'(READ_PORT); // Let decode free a bank
		@(negedge clk);
		waited++;
	end
	if (!fetch_ready_o) begin
		$display("Packet was never accepted within %0d cycles at %0d ns", HOLD_LIMIT, $time);
		error_count++;
	end
endtask

task automatic drain_buffer();
	int waited;
	waited = 0;
	@(posedge clk);
	fetch_valid_i <= 1'b0;
	dec_slots_i <= rd_cnt_t'(READ_PORT);
	@(negedge clk);
	while (dec_valid_o != '0 && waited < DRAIN_LIMIT) begin
		@(negedge clk);
		waited++;
	end
	if (dec_valid_o != '0) begin
		$display("Buffer did not drain within %0d cycles at %0d ns", DRAIN_LIMIT, $time);
		error_count++;
	end
endtask

task automatic test_reset_state();
	@(negedge clk);
	check_mask("dec_valid_o after reset", dec_valid_o, '0);
	check_cnt("dec_taken_o after reset", dec_taken_o, '0);
	check_flag("fetch_ready_o after reset", fetch_ready_o, 1'b1);
endtask

task automatic test_order();
	for (int i = 0; i < 12; i++) begin
		send_packet('1, rd_cnt_t'(i % 3));
	end
	drain_buffer();
endtask

task automatic test_compaction();
	wr_mask_t masks [4] = '{2'b01, 2'b10, 2'b00, 2'b11};
	for (int r = 0; r < 3; r++) begin
		for (int m = 0; m < 4; m++) begin
			send_packet(masks[m], rd_cnt_t'(1));
		end
	end
	drain_buffer();
endtask

task automatic test_backpressure();
	int sent;
	int waited;
	sent = 0;
	waited = 0;
	drain_buffer();
	do begin
		@(posedge clk);
		fetch_valid_i <= 1'b1;
		fetch_mask_i <= '1;
		fetch_instr_i <= random_lanes();
		dec_slots_i <= '0;
		@(negedge clk);
		sent++;
	end while (fetch_ready_o && sent < 2 * BANK * DEPTH);
	if (fetch_ready_o) begin
		$display("fetch_ready_o stayed high after %0d packets with decode stalled", sent);
		error_count++;
	end
	repeat (3) @(negedge clk); // Held packet must stay pending
	@(posedge clk);
	dec_slots_i <= rd_cnt_t'(READ_PORT);
	do begin
		@(negedge clk);
		waited++;
	end while (!fetch_ready_o && waited < HOLD_LIMIT);
	if (!fetch_ready_o) begin
		$display("Held packet was not accepted after decode slots reopened");
		error_count++;
	end
	@(posedge clk);
	fetch_valid_i <= 1'b0; // This edge takes the held packet
	drain_buffer();
endtask

task automatic test_flush();
	drain_buffer();
	for (int i = 0; i < 5; i++) begin
		send_packet('1, '0);
	end
	@(posedge clk);
	fetch_valid_i <= 1'b1;
	fetch_mask_i <= '1;
	fetch_instr_i <= random_lanes();
	dec_slots_i <= rd_cnt_t'(1);
	flush_i <= 1'b1; // Overrides this write and read
	@(posedge clk);
	flush_i <= 1'b0;
	fetch_valid_i <= 1'b0;
	@(negedge clk);
	check_mask("dec_valid_o after flush", dec_valid_o, '0);
	for (int i = 0; i < 4; i++) begin
		send_packet('1, rd_cnt_t'(1));
	end
	drain_buffer();
endtask

`endif

//--- tb_instr_buffer.sv
`timescale 1ns/1ps

module tb_instr_buffer import ibuf_cfg_pkg::*, instr_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 3;
	localparam int HOLD_LIMIT = 20; // Cycles a packet may wait for ready
	localparam int DRAIN_LIMIT = 40;
	// Reset, order, compaction, back-pressure and flush budgets
	localparam int BUDGET_CYCLES = 10 + 60 + 50 + 80 + 60;
	localparam int MARGIN_CYCLES = 50;

	logic clk = 1'b0;
	logic rst_i;
	logic flush_i;
	logic fetch_valid_i;
	wr_mask_t fetch_mask_i;
	wr_lanes_t fetch_instr_i;
	logic fetch_ready_o;
	rd_mask_t dec_valid_o;
	rd_lanes_t dec_instr_o;
	rd_cnt_t dec_slots_i;
	rd_cnt_t dec_taken_o;

	integer seed = 69;
	int error_count = 0;
	int check_count = 0;

	instr_buffer i_dut (
		.clk           (clk),
		.rst_i         (rst_i),
		.flush_i       (flush_i),
		.fetch_valid_i (fetch_valid_i),
		.fetch_mask_i  (fetch_mask_i),
		.fetch_instr_i (fetch_instr_i),
		.fetch_ready_o (fetch_ready_o),
		.dec_valid_o   (dec_valid_o),
		.dec_instr_o   (dec_instr_o),
		.dec_slots_i   (dec_slots_i),
		.dec_taken_o   (dec_taken_o)
	);

	`include "tb_instr_buffer_tasks.svh"

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_instr(input string name, input instr_t act, input instr_t exp);
		check_count++;
		if (act !== exp) begin
			$display("[ERROR] %0d ns %s: expected %h, got %h", $time, name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_mask(input string name, input rd_mask_t act, input rd_mask_t exp);
		check_count++;
		if (act !== exp) begin
			$display("[ERROR] %0d ns %s: expected %b, got %b", $time, name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_cnt(input string name, input rd_cnt_t act, input rd_cnt_t exp);
		check_count++;
		if (act !== exp) begin
			$display("[ERROR] %0d ns %s: expected %0d, got %0d", $time, name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic act, input logic exp);
		check_count++;
		if (act !== exp) begin
			$display("[ERROR] %0d ns %s: expected %b, got %b", $time, name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_outputs();
		rd_mask_t exp_mask;
		exp_mask = exp_valid();
		check_mask("dec_valid_o", dec_valid_o, exp_mask);
		for (int i = 0; i < READ_PORT; i++) begin
			if (exp_mask[i]) begin
				check_instr($sformatf("dec_instr_o[%0d]", i), dec_instr_o[i], model_q[i]);
			end
		end
		check_cnt("dec_taken_o", dec_taken_o, exp_taken());
		check_flag("fetch_ready_o", fetch_ready_o, exp_ready());
	endtask

	// Mid-cycle, inputs and outputs are settled
	always @(negedge clk) begin
		if (rst_i) begin
			model_reset();
		end else begin
			check_outputs();
			model_step(); // State after the coming edge
		end
	end

	initial begin
		#((BUDGET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: the tests did not finish within the cycle budget");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		rst_i = 1'b1;
		flush_i = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_mask_i = '0;
		fetch_instr_i = '0;
		dec_slots_i = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_i <= 1'b0;

		test_reset_state();
		test_order();
		test_compaction();
		test_backpressure();
		test_flush();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer import ibuf_cfg_pkg::*, instr_pkg::*; (
	input logic clk,
	input logic rst_i,
	input logic flush_i,

	input logic fetch_valid_i,
	input wr_mask_t fetch_mask_i,
	input wr_lanes_t fetch_instr_i,
	output logic fetch_ready_o,

	output rd_mask_t dec_valid_o,
	output rd_lanes_t dec_instr_o,
	input rd_cnt_t dec_slots_i,
	output rd_cnt_t dec_taken_o
);

	wr_cnt_t write_num;
	wr_lanes_t write_data;

	fetch_align i_fetch_align (
		.fetch_mask_i  (fetch_mask_i),
		.fetch_instr_i (fetch_instr_i),
		.write_num_o   (write_num),
		.write_data_o  (write_data)
	);

	multi_channel_fifo i_fifo (
		.clk           (clk),
		.rst_i         (rst_i),
		.flush_i       (flush_i),
		.write_valid_i (fetch_valid_i),
		.write_ready_o (fetch_ready_o),
		.write_num_i   (write_num),
		.write_data_i  (write_data),
		.read_valid_o  (dec_valid_o),
		.read_num_i    (dec_taken_o), // Pops what decode takes
		.read_data_o   (dec_instr_o)
	);

	dispatch_count i_dispatch_count (
		.read_valid_i (dec_valid_o),
		.dec_slots_i  (dec_slots_i),
		.read_num_o   (dec_taken_o)
	);

endmodule

//--- multi_channel_fifo.sv
`timescale 1ns/1ps

module multi_channel_fifo import ibuf_cfg_pkg::*, instr_pkg::*; (
	input logic clk,
	input logic rst_i,
	input logic flush_i,

	input logic write_valid_i,
	output logic write_ready_o,
	input wr_cnt_t write_num_i,
	input wr_lanes_t write_data_i,

	output rd_mask_t read_valid_o,
	input rd_cnt_t read_num_i,
	output rd_lanes_t read_data_o
);

	// Per bank, the lane offset it takes relative to the current write/read head
	bank_idx_t port_write_idx [BANK];
	bank_idx_t port_read_idx [BANK];

	logic [BANK-1:0] bank_push;
	logic [BANK-1:0] bank_pop;
	logic [BANK-1:0] bank_full;
	logic [BANK-1:0] bank_empty;
	instr_t bank_din [BANK];
	instr_t bank_dout [BANK];

	bank_cnt_t full_cnt;
	logic write_fire;

	always_comb begin
		full_cnt = '0;
		for (int b = 0; b < BANK; b++) begin
			full_cnt = full_cnt + bank_cnt_t'(bank_full[b]);
		end
	end

	// Room for a whole packet whatever its mask
	assign write_ready_o = (full_cnt <= bank_cnt_t'(BANK - WRITE_PORT));
	assign write_fire = write_valid_i && write_ready_o;

	always_ff @(posedge clk) begin
		if (rst_i || flush_i) begin
			for (int b = 0; b < BANK; b++) begin
				port_write_idx[b] <= bank_idx_t'(b);
				port_read_idx[b] <= bank_idx_t'(b);
			end
		end else begin
			for (int b = 0; b < BANK; b++) begin
				if (write_fire) begin
					port_write_idx[b] <= port_write_idx[b] - bank_idx_t'(write_num_i);
				end
				port_read_idx[b] <= port_read_idx[b] - bank_idx_t'(read_num_i); // Zero means hold
			end
		end
	end

	// Route write lane k into the bank whose port offset is k
	always_comb begin
		for (int b = 0; b < BANK; b++) begin
			bank_din[b] = write_data_i[0];
			for (int k = 0; k < WRITE_PORT; k++) begin
				if (port_write_idx[b] == bank_idx_t'(k)) begin
					bank_din[b] = write_data_i[k];
				end
			end
			bank_push[b] = !flush_i && write_fire
				&& (port_write_idx[b] < bank_idx_t'(write_num_i));
			bank_pop[b] = !flush_i && (port_read_idx[b] < bank_idx_t'(read_num_i));
		end
	end

	for (genvar b = 0; b < BANK; b++) begin : g_bank
		bank_fifo i_bank (
			.clk     (clk),
			.rst_i   (rst_i),
			.flush_i (flush_i),
			.push_i  (bank_push[b]),
			.pop_i   (bank_pop[b]),
			.data_i  (bank_din[b]),
			.data_o  (bank_dout[b]),
			.full_o  (bank_full[b]),
			.empty_o (bank_empty[b])
		);
	end

	// Output lane i is the bank at read rotation i, lane 0 oldest
	always_comb begin
		read_data_o = '0;
		read_valid_o = '0;
		for (int i = 0; i < READ_PORT; i++) begin
			for (int b = 0; b < BANK; b++) begin
				if (port_read_idx[b] == bank_idx_t'(i)) begin
					read_data_o[i] = bank_dout[b];
					read_valid_o[i] = !bank_empty[b];
				end
			end
		end
	end

	// Reading lane i needs lanes 0..i valid, so read_num stays within the leading run
	for (genvar i = 0; i < READ_PORT; i++) begin : g_rd_chk
		a_read_in_run: assert property (
			@(posedge clk) disable iff (rst_i || flush_i)
			(read_num_i > rd_cnt_t'(i)) |-> read_valid_o[i]
		) else $error("multi_channel_fifo: read beyond valid lanes");
	end

	a_write_num: assert property (
		@(posedge clk) disable iff (rst_i)
		write_valid_i |-> (write_num_i <= wr_cnt_t'(WRITE_PORT))
	) else $error("multi_channel_fifo: write_num above WRITE_PORT");

endmodule

//--- dispatch_count.sv
`timescale 1ns/1ps

module dispatch_count import ibuf_cfg_pkg::*, instr_pkg::*; (
	input rd_mask_t read_valid_i,
	input rd_cnt_t dec_slots_i,
	output rd_cnt_t read_num_o
);

	// Count valid lanes from lane 0 up to the first hole
	always_comb begin
		rd_cnt_t lead;
		logic hole;
		lead = '0;
		hole = 1'b0;
		for (int i = 0; i < READ_PORT; i++) begin
			if (!read_valid_i[i]) begin
				hole = 1'b1;
			end else if (!hole) begin
				lead = lead + rd_cnt_t'(1);
			end
		end
		read_num_o = (dec_slots_i < lead) ? dec_slots_i : lead; // Limited by decode slots
	end

endmodule

//--- fetch_align.sv
`timescale 1ns/1ps

module fetch_align import ibuf_cfg_pkg::*, instr_pkg::*; (
	input wr_mask_t fetch_mask_i,
	input wr_lanes_t fetch_instr_i,
	output wr_cnt_t write_num_o,
	output wr_lanes_t write_data_o
);

	// Lane j moves down to the number of valid lanes below it
	always_comb begin
		wr_cnt_t below;
		below = '0;
		write_data_o = '0; // Lanes at or above write_num_o unused
		for (int j = 0; j < WRITE_PORT; j++) begin
			for (int k = 0; k < WRITE_PORT; k++) begin
				if (fetch_mask_i[j] && (below == wr_cnt_t'(k))) begin
					write_data_o[k] = fetch_instr_i[j];
				end
			end
			below = below + wr_cnt_t'(fetch_mask_i[j]);
		end
		write_num_o = below; // Total set bits
	end

endmodule

//--- bank_fifo.sv
`timescale 1ns/1ps

module bank_fifo import ibuf_cfg_pkg::*, instr_pkg::*; (
	input logic clk,
	input logic rst_i,
	input logic flush_i,
	input logic push_i,
	input logic pop_i,
	input instr_t data_i,
	output instr_t data_o,
	output logic full_o,
	output logic empty_o
);

	typedef logic [$clog2(DEPTH)-1:0] slot_t;

	instr_t mem [DEPTH];
	slot_t wr_ptr;
	slot_t rd_ptr;
	fill_t fill;

	assign full_o = (fill == fill_t'(DEPTH));
	assign empty_o = (fill == '0);
	assign data_o = mem[rd_ptr]; // Head shown without a register stage

	always_ff @(posedge clk) begin
		if (push_i) begin
			mem[wr_ptr] <= data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i || flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= wr_ptr + slot_t'(1); // Wraps at DEPTH
			end
			if (pop_i) begin
				rd_ptr <= rd_ptr + slot_t'(1);
			end
			case ({push_i, pop_i})
				2'b10: fill <= fill + fill_t'(1);
				2'b01: fill <= fill - fill_t'(1);
				default: fill <= fill;
			endcase
		end
	end

	// The banked FIFO must never steer a write into a full bank
	a_no_push_full: assert property (
		@(posedge clk) disable iff (rst_i || flush_i)
		full_o |-> !push_i
	) else $error("bank_fifo: push while full");

	// Decode may only consume entries that are shown as valid
	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (rst_i || flush_i)
		empty_o |-> !pop_i
	) else $error("bank_fifo: pop while empty");

endmodule

//--- instr_pkg.sv
package instr_pkg;

	import ibuf_cfg_pkg::*;

	localparam int INSTR_WIDTH = 32;

	typedef logic [INSTR_WIDTH-1:0] instr_t;

	// Lane 0 sits in the low word
	typedef instr_t [WRITE_PORT-1:0] wr_lanes_t;
	typedef instr_t [READ_PORT-1:0] rd_lanes_t;

	typedef logic [WRITE_PORT-1:0] wr_mask_t;
	typedef logic [READ_PORT-1:0] rd_mask_t;

endpackage

//--- ibuf_cfg_pkg.sv
package ibuf_cfg_pkg;

	localparam int BANK = 4; // Bank FIFOs
	localparam int DEPTH = 4; // Entries per bank
	localparam int WRITE_PORT = 2; // Fetch lanes per cycle
	localparam int READ_PORT = 2; // Decode lanes per cycle

	// Bank selector and port-relative rotation index
	typedef logic [$clog2(BANK)-1:0] bank_idx_t;

	// Number of full banks, 0 to BANK
	typedef logic [$clog2(BANK+1)-1:0] bank_cnt_t;

	// Instructions written in one cycle, 0 to WRITE_PORT
	typedef logic [$clog2(WRITE_PORT+1)-1:0] wr_cnt_t;

	// Instructions read in one cycle, 0 to READ_PORT
	typedef logic [$clog2(READ_PORT+1)-1:0] rd_cnt_t;

	// Occupancy of a single bank, 0 to DEPTH
	typedef logic [$clog2(DEPTH+1)-1:0] fill_t;

endpackage
